/* div_pkg.sv */
`default_nettype none

package div_pkg;

    localparam int xlen   = 64;
    localparam int log2_w = 7;                 // Leading-one position width
    localparam int cnt_w  = 5;                 // Core step counter width

    // Bit 1 of the operation code selects remainder and bit 0 selects unsigned
    localparam logic [1:0] op_div  = 2'b00;
    localparam logic [1:0] op_divu = 2'b01;
    localparam logic [1:0] op_rem  = 2'b10;
    localparam logic [1:0] op_remu = 2'b11;

    // Last core counter value before the output register
    localparam logic [cnt_w-1:0] div_iters_q = 5'd14;
    localparam logic [cnt_w-1:0] div_iters_r = 5'd15;

    // Core schedule points
    localparam logic [cnt_w-1:0] nr_last_step = 5'd9;    // Last Newton-Raphson update
    localparam logic [cnt_w-1:0] q_est_step   = 5'd10;   // Reciprocal times dividend
    localparam logic [cnt_w-1:0] remul_step   = 5'd11;   // Quotient times divisor

    // Whole-unit latency from the op_valid sample edge to the result_valid sample edge
    localparam int lat_quot = 17;
    localparam int lat_rem  = 18;

    // Fixed-point constants in Q64
    localparam logic [65:0]  recip_c32 = 66'h1e1e1e1e1e1e1e1e1;   // 32/17
    localparam logic [65:0]  recip_c48 = 66'h2d2d2d2d2d2d2d2d2;   // 48/17
    localparam logic [128:0] fix_one   = 129'h1_0000_0000_0000_0000;

endpackage

`default_nettype wire

/* div_decode.sv */
`default_nettype none

module div_decode
    import div_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             op_valid,
    input  wire [1:0]       op,
    input  wire             word,
    input  wire [xlen-1:0]  a,
    input  wire [xlen-1:0]  b,
    input  wire             core_valid,
    output logic            start,
    output logic            do_rem,
    output logic [xlen-1:0] mag_a,
    output logic [xlen-1:0] mag_b,
    output logic            negate,
    output logic            div_zero,
    output logic            overflow,
    output logic            is_rem,
    output logic            is_word,
    output logic [xlen-1:0] orig_a,
    output logic            busy
);

    logic            uns;
    logic            rem_op;
    logic [xlen-1:0] a_ext;
    logic [xlen-1:0] b_ext;
    logic            sign_a;
    logic            sign_b;
    logic [xlen-1:0] min_val;
    logic            zero_n;
    logic            ovf_n;
    logic            done_d;

    assign uns    = (op == op_divu) || (op == op_remu);
    assign rem_op = (op == op_rem) || (op == op_remu);

    always_comb begin
        if (word) begin
            a_ext = uns ? {32'b0, a[31:0]} : {{32{a[31]}}, a[31:0]};
            b_ext = uns ? {32'b0, b[31:0]} : {{32{b[31]}}, b[31:0]};
        end else begin
            a_ext = a;
            b_ext = b;
        end
    end

    assign sign_a  = !uns && a_ext[xlen-1];
    assign sign_b  = !uns && b_ext[xlen-1];
    assign min_val = word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
    assign zero_n  = (b_ext == '0);
    assign ovf_n   = !uns && (a_ext == min_val) && (b_ext == '1);

    // Operand registers loaded once per operation
    always_ff @(posedge clk) begin
        if (op_valid) begin
            mag_a    <= sign_a ? -a_ext : a_ext;
            mag_b    <= (zero_n || ovf_n) ? 64'd1 : (sign_b ? -b_ext : b_ext);  // Safe divisor
            negate   <= rem_op ? sign_a : (sign_a ^ sign_b);
            div_zero <= zero_n;
            overflow <= ovf_n;
            is_rem   <= rem_op;
            is_word  <= word;
            orig_a   <= a;
        end
    end

    assign do_rem = is_rem;                    // Held until the next operation

    always_ff @(posedge clk) begin
        if (rst) begin
            start  <= 1'b0;
            busy   <= 1'b0;
            done_d <= 1'b0;
        end else begin
            start  <= op_valid;
            done_d <= core_valid;              // Result register fills this cycle
            if (op_valid) begin
                busy <= 1'b1;
            end else if (done_d) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* exec_div.sv */
`default_nettype none

// Unsigned Newton-Raphson divider for a nonzero divisor
module exec_div
    import div_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire [xlen-1:0]  a_in,
    input  wire [xlen-1:0]  b_in,
    input  wire             do_rem,
    input  wire             input_valid,
    output logic [xlen-1:0] q_out,
    output logic            output_valid
);

    // Returns one plus the index of the highest set bit
    function automatic logic [log2_w-1:0] lead_one(input logic [xlen-1:0] n);
        logic [log2_w-1:0] pos;
        pos = '0;
        for (int i = 0; i < xlen; i++) begin
            if (n[i]) begin
                pos = log2_w'(i + 1);
            end
        end
        return pos;
    endfunction

    logic [65:0]         mult_a;               // Unsigned operand
    logic signed [128:0] mult_b;               // Signed operand
    logic signed [195:0] mult_p;
    logic signed [127:0] mult_r;               // Product in Q64

    logic [log2_w-1:0]   b_lead;
    logic [log2_w-1:0]   norm_sh;
    logic [127:0]        a_n;                  // Normalized dividend
    logic [63:0]         b_n;                  // Normalized divisor in [0.5, 1)
    logic [63:0]         a_buf;
    logic [63:0]         b_buf;
    logic [65:0]         x;                    // Reciprocal estimate
    logic [65:0]         x_sum;
    logic [65:0]         recip0;
    logic signed [128:0] err;
    logic [63:0]         q_est;
    logic [63:0]         q;
    logic signed [129:0] diff;                 // Running remainder
    logic signed [129:0] diff_init;
    logic signed [129:0] b_ext;
    logic signed [129:0] d_src;
    logic signed [129:0] d_fix;
    logic [63:0]         q_fix;
    logic [cnt_w-1:0]    counter;
    logic [cnt_w-1:0]    counter_max;

    // Shared fixed-point multiplier
    assign mult_p = $signed({1'b0, mult_a}) * mult_b;
    assign mult_r = $signed(mult_p[191:64]);

    assign b_lead  = lead_one(b_in);
    assign norm_sh = log2_w'(xlen) - b_lead;

    assign recip0 = recip_c48 - mult_r[65:0];            // 48/17 - 32/17 * b
    assign x_sum  = x + mult_r[65:0];
    assign err    = fix_one - {mult_r[127], mult_r};     // 1 - b * x
    assign q_est  = (|mult_p[195:192]) ? '1 : mult_p[191:128];

    assign b_ext     = $signed({66'b0, b_buf});
    assign diff_init = $signed({66'b0, a_buf}) - $signed({2'b0, mult_r});

    // Quotient correction by up to two steps per cycle
    always_comb begin
        d_src = (counter == remul_step) ? diff_init : diff;
        q_fix = q;
        d_fix = d_src;
        if (d_src < -b_ext) begin
            q_fix = q - 64'd2;
            d_fix = d_src + (b_ext <<< 1);
        end else if (d_src < 0) begin
            q_fix = q - 64'd1;
            d_fix = d_src + b_ext;
        end else if (d_src >= (b_ext <<< 1)) begin
            q_fix = q + 64'd2;
            d_fix = d_src - (b_ext <<< 1);
        end else if (d_src >= b_ext) begin
            q_fix = q + 64'd1;
            d_fix = d_src - b_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (input_valid) begin
            a_n    <= 128'(a_in) << norm_sh;
            b_n    <= b_in << norm_sh;
            a_buf  <= a_in;
            b_buf  <= b_in;
            mult_a <= recip_c32;
            mult_b <= $signed({65'b0, b_in << norm_sh});
        end else if (counter == 5'd1) begin
            x      <= recip0;                  // Seed estimate
            mult_a <= {2'b0, b_n};
            mult_b <= $signed({63'b0, recip0});
        end else if (counter == nr_last_step) begin
            mult_a <= x_sum;                   // Final reciprocal times dividend
            mult_b <= $signed({1'b0, a_n});
        end else if (counter == q_est_step) begin
            q      <= q_est;
            mult_a <= {2'b0, q_est};           // Remultiply by the divisor
            mult_b <= $signed({1'b0, b_buf, 64'b0});
        end else if (counter >= remul_step) begin
            q      <= q_fix;
            diff   <= d_fix;
        end else if (counter != '0 && !counter[0]) begin
            mult_a <= x;                       // x * (1 - b * x)
            mult_b <= err;
        end else if (counter != '0) begin
            x      <= x_sum;
            mult_a <= {2'b0, b_n};
            mult_b <= $signed({63'b0, x_sum});
        end
    end

    assign counter_max = do_rem ? div_iters_r : div_iters_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            counter <= '0;
        end else if (input_valid) begin
            counter <= 5'd1;
        end else if (counter == counter_max) begin
            counter <= '0;
        end else if (counter != '0) begin
            counter <= counter + 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            output_valid <= 1'b0;
        end else begin
            output_valid <= (counter == counter_max);
        end
    end

    // For a remainder the caller gets q * b back
    always_ff @(posedge clk) begin
        if (counter == counter_max) begin
            q_out <= do_rem ? (a_buf - diff[63:0]) : q;
        end
    end

endmodule

`default_nettype wire

/* div_result.sv */
`default_nettype none

module div_result
    import div_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             core_valid,
    input  wire [xlen-1:0]  core_q,
    input  wire [xlen-1:0]  mag_a,
    input  wire             negate,
    input  wire             div_zero,
    input  wire             overflow,
    input  wire             is_rem,
    input  wire             is_word,
    input  wire [xlen-1:0]  orig_a,
    output logic            result_valid,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] mag_res;
    logic [xlen-1:0] signed_res;
    logic [xlen-1:0] final_res;

    assign mag_res    = is_rem ? (mag_a - core_q) : core_q;   // Remainder from q * b
    assign signed_res = negate ? -mag_res : mag_res;

    always_comb begin
        if (div_zero) begin
            final_res = is_rem ? orig_a : '1;
        end else if (overflow) begin
            // Dividend is the most negative value here, which is also the quotient
            final_res = is_rem ? '0 : orig_a;
        end else begin
            final_res = signed_res;
        end
        if (is_word) begin
            final_res = {{32{final_res[31]}}, final_res[31:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= core_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (core_valid) begin
            result <= final_res;
        end
    end

endmodule

`default_nettype wire

/* div_unit.sv */
`default_nettype none

module div_unit
    import div_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             op_valid,
    input  wire [1:0]       op,
    input  wire             word,
    input  wire [xlen-1:0]  a,
    input  wire [xlen-1:0]  b,
    output logic            busy,
    output logic            result_valid,
    output logic [xlen-1:0] result
);

    logic            start;
    logic            do_rem;
    logic [xlen-1:0] mag_a;
    logic [xlen-1:0] mag_b;
    logic            negate;
    logic            div_zero;
    logic            overflow;
    logic            is_rem;
    logic            is_word;
    logic [xlen-1:0] orig_a;
    logic            core_valid;
    logic [xlen-1:0] core_q;

    div_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .word       (word),
        .a          (a),
        .b          (b),
        .core_valid (core_valid),
        .start      (start),
        .do_rem     (do_rem),
        .mag_a      (mag_a),
        .mag_b      (mag_b),
        .negate     (negate),
        .div_zero   (div_zero),
        .overflow   (overflow),
        .is_rem     (is_rem),
        .is_word    (is_word),
        .orig_a     (orig_a),
        .busy       (busy)
    );

    exec_div u_exec (
        .clk          (clk),
        .rst          (rst),
        .a_in         (mag_a),
        .b_in         (mag_b),
        .do_rem       (do_rem),
        .input_valid  (start),
        .q_out        (core_q),
        .output_valid (core_valid)
    );

    div_result u_result (
        .clk          (clk),
        .rst          (rst),
        .core_valid   (core_valid),
        .core_q       (core_q),
        .mag_a        (mag_a),
        .negate       (negate),
        .div_zero     (div_zero),
        .overflow     (overflow),
        .is_rem       (is_rem),
        .is_word      (is_word),
        .orig_a       (orig_a),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int half_period = 2;            // Period of 4

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule

`default_nettype wire

/* div_unit_props.sv */
`default_nettype none

module div_unit_props
    import div_pkg::*;
(
    input wire            clk,
    input wire            rst,
    input wire            op_valid,
    input wire [1:0]      op,
    input wire            word,
    input wire [xlen-1:0] a,
    input wire [xlen-1:0] b,
    input wire            busy,
    input wire            result_valid
);

    // One operation at a time
    a_idle_strobe: assert property (@(posedge clk) disable iff (rst)
        op_valid |-> !busy)
        else $error("op_valid strobed while the unit was busy");

    a_lat_quot: assert property (@(posedge clk) disable iff (rst)
        op_valid && !op[1] |-> ##lat_quot result_valid)
        else $error("Quotient result did not arrive after the fixed latency");

    a_lat_rem: assert property (@(posedge clk) disable iff (rst)
        op_valid && op[1] |-> ##lat_rem result_valid)
        else $error("Remainder result did not arrive after the fixed latency");

    a_pulse: assert property (@(posedge clk) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("result_valid stayed high for more than one cycle");

    a_known: assert property (@(posedge clk) disable iff (rst)
        op_valid |-> !$isunknown({op, word, a, b}))
        else $error("Operation or operands unknown at the strobe");

endmodule

bind div_unit div_unit_props u_props (
    .clk          (clk),
    .rst          (rst),
    .op_valid     (op_valid),
    .op           (op),
    .word         (word),
    .a            (a),
    .b            (b),
    .busy         (busy),
    .result_valid (result_valid)
);

`default_nettype wire

/* div_unit_tb.sv */
`default_nettype none

module div_unit_tb
    import div_pkg::*;
;

    localparam int          n_ops      = 76;                // Operations issued by all tests
    localparam int          max_cycles = 200 * n_ops;
    localparam logic [31:0] rand_seed  = 32'h470b_0e94;

    wire             clk;
    logic            rst;
    logic            op_valid;
    logic [1:0]      op;
    logic            word;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    wire             busy;
    wire             result_valid;
    wire [xlen-1:0]  result;
    int              cycle_count;

    tb_clock u_clock (
        .clk (clk)
    );

    div_unit u_div_unit (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .op           (op),
        .word         (word),
        .a            (a),
        .b            (b),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Something failed");
            $fatal(1, "run stopped by the watchdog");
        end
    end

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // RISC-V M-extension divide rules
    function automatic logic [63:0] ref_div(input logic [1:0] op_c, input logic w,
                                            input logic [63:0] x, input logic [63:0] y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic [31:0]        ux;
        logic [31:0]        uy;
        logic signed [31:0] wx;
        logic signed [31:0] wy;
        logic [31:0]        r32;
        logic [63:0]        r;
        sx = x;
        sy = y;
        ux = x[31:0];
        uy = y[31:0];
        wx = ux;
        wy = uy;
        if (w) begin
            if (uy == '0) begin
                r32 = op_c[1] ? ux : '1;
            end else if (!op_c[0] && ux == 32'h8000_0000 && uy == '1) begin
                r32 = op_c[1] ? '0 : ux;
            end else if (op_c[0]) begin
                r32 = op_c[1] ? ux % uy : ux / uy;
            end else if (op_c[1]) begin
                r32 = wx % wy;
            end else begin
                r32 = wx / wy;
            end
            r = {{32{r32[31]}}, r32};
        end else begin
            if (y == '0) begin
                r = op_c[1] ? x : '1;
            end else if (!op_c[0] && x == 64'h8000_0000_0000_0000 && y == '1) begin
                r = op_c[1] ? '0 : x;
            end else if (op_c[0]) begin
                r = op_c[1] ? x % y : x / y;
            end else if (op_c[1]) begin
                r = sx % sy;
            end else begin
                r = sx / sy;
            end
        end
        return r;
    endfunction

    // Strobe one operation, follow busy and check latency and result
    task automatic run_op(input logic [1:0] op_c, input logic w,
                          input logic [63:0] x, input logic [63:0] y);
        logic [63:0] expected;
        string       label;
        int          cycles;
        logic        done;
        expected = ref_div(op_c, w, x, y);
        label    = $sformatf("op %0d word %0b a %h b %h", op_c, w, x, y);
        @(posedge clk);
        op_valid <= 1'b1;
        op       <= op_c;
        word     <= w;
        a        <= x;
        b        <= y;
        @(posedge clk);                        // This edge samples the strobe
        op_valid <= 1'b0;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            check_eq(64'(busy), 64'd1, {"busy while running ", label});
            done = result_valid;
        end
        check_eq(64'(cycles), op_c[1] ? 64'(lat_rem) : 64'(lat_quot), {"latency of ", label});
        check_eq(result, expected, {"result of ", label});
        @(posedge clk);
        check_eq(64'(result_valid), 64'd0, {"result_valid pulse width, ", label});
        check_eq(64'(busy), 64'd0, {"busy after result, ", label});
    endtask

    function automatic logic [63:0] rand_divisor();
        logic [63:0] y;
        y = {$urandom, $urandom} >> ($urandom % 64);   // Spread divisor sizes
        if (y == '0) begin
            y = 64'd1;
        end
        return y;
    endfunction

    task automatic unsigned_ops();
        logic [63:0] x;
        logic [63:0] y;
        for (int i = 0; i < 2; i++) begin
            run_op(i[0] ? op_remu : op_divu, 1'b0, 64'h0123_4567_89ab_cdef, 64'd1);
            run_op(i[0] ? op_remu : op_divu, 1'b0, '1, '1);
            run_op(i[0] ? op_remu : op_divu, 1'b0, '1, 64'd3);
            run_op(i[0] ? op_remu : op_divu, 1'b0, 64'hffff_ffff_ffff_fffe, '1);
        end
        for (int i = 0; i < 16; i++) begin
            x = {$urandom, $urandom};
            y = rand_divisor();
            run_op(i[0] ? op_remu : op_divu, 1'b0, x, y);
        end
    endtask

    task automatic signed_ops();
        logic [63:0] pa;
        logic [63:0] pb;
        pa = 64'd7_000_000_019;
        pb = 64'd13;
        for (int i = 0; i < 4; i++) begin
            run_op(op_div, 1'b0, i[0] ? -pa : pa, i[1] ? -pb : pb);
            run_op(op_rem, 1'b0, i[0] ? -pa : pa, i[1] ? -pb : pb);
        end
        for (int i = 0; i < 16; i++) begin
            run_op(i[0] ? op_rem : op_div, 1'b0, {$urandom, $urandom}, rand_divisor());
        end
    endtask

    task automatic zero_divisor();
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < 4; k++) begin
                // Word divisor has a nonzero upper half that must be ignored
                run_op(2'(k), w[0], {$urandom, $urandom},
                       w[0] ? 64'hdead_beef_0000_0000 : 64'd0);
            end
        end
    endtask

    task automatic signed_overflow();
        run_op(op_div, 1'b0, 64'h8000_0000_0000_0000, '1);
        run_op(op_rem, 1'b0, 64'h8000_0000_0000_0000, '1);
        run_op(op_div, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
        run_op(op_rem, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    endtask

    task automatic word_ops();
        logic [63:0] y;
        for (int i = 0; i < 16; i++) begin
            y = {$urandom, $urandom >> ($urandom % 32)};
            if (y[31:0] == '0) begin
                y[0] = 1'b1;
            end
            run_op(2'(i % 4), 1'b1, {$urandom, $urandom}, y);
        end
    endtask

    initial begin
        rst         = 1'b1;
        op_valid    = 1'b0;
        op          = '0;
        word        = 1'b0;
        a           = '0;
        b           = '0;
        cycle_count = 0;
        void'($urandom(rand_seed));
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        unsigned_ops();
        signed_ops();
        zero_divisor();
        signed_overflow();
        word_ops();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
div_pkg.sv
div_decode.sv
exec_div.sv
div_result.sv
div_unit.sv
tb_clock.sv
div_unit_props.sv
div_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run the divide unit testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module div_unit_tb \
    -o sim_div_unit \
    && ./obj_dir/sim_div_unit | grep "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
